//--- logic/riscv_fd_macros.svh
`ifndef RISCV_FD_MACROS_SVH
`define RISCV_FD_MACROS_SVH

// datapath widths
`define RISCV_FD_XLEN 64
`define RISCV_FD_ILEN 32

// fetch address out of reset
`define RISCV_FD_RESET_PC 64'h0000_0000_8000_0000

// ######################################################################
// rv64i major opcodes
// ######################################################################
`define RISCV_FD_OP_LUI    7'b0110111
`define RISCV_FD_OP_AUIPC  7'b0010111
`define RISCV_FD_OP_JAL    7'b1101111
`define RISCV_FD_OP_JALR   7'b1100111
`define RISCV_FD_OP_BRANCH 7'b1100011
`define RISCV_FD_OP_LOAD   7'b0000011
`define RISCV_FD_OP_STORE  7'b0100011
`define RISCV_FD_OP_OPIMM  7'b0010011
`define RISCV_FD_OP_OP     7'b0110011

`endif

//--- logic/riscv_fd_pkg.sv
`include "riscv_fd_macros.svh"

package riscv_fd_pkg;

  // ######################################################################
  // base instruction formats, msb first
  // ######################################################################
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  // one word, every format view overlaid
  typedef union packed {
    inst_r_t                   r;
    inst_i_t                   i;
    inst_s_t                   s;
    inst_b_t                   b;
    inst_u_t                   u;
    inst_j_t                   j;
    logic [`RISCV_FD_ILEN-1:0] raw;
  } inst_u;

  // decoded instruction class
  typedef enum logic [3:0] {
    BUBBLE  = 4'd0,  // all-zero word
    LUI     = 4'd1,
    AUIPC   = 4'd2,
    JAL     = 4'd3,
    JALR    = 4'd4,
    BRANCH  = 4'd5,
    LOAD    = 4'd6,
    STORE   = 4'd7,
    OPIMM   = 4'd8,
    OP      = 4'd9,
    ILLEGAL = 4'd15
  } inst_class_e;

endpackage

//--- logic/riscv_fd_stage_if.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

// one fetched instruction moving between stages
interface riscv_fd_stage_if;

  logic [`RISCV_FD_XLEN-1:0] pc;       // address of the word
  logic [`RISCV_FD_ILEN-1:0] inst;     // 32-bit form, expanded if compressed
  logic [`RISCV_FD_XLEN-1:0] pcplus4;  // next sequential pc
  logic [15:0]               cinst;    // raw rvc halfword, zero otherwise

  // producer side
  modport fetch (
    output pc,
    output inst,
    output pcplus4,
    output cinst
  );

  // consumer side
  modport decode (
    input  pc,
    input  inst,
    input  pcplus4,
    input  cinst
  );

endinterface

//--- logic/riscv_fd_pcgen.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_pcgen (
  input  logic                      i_riscv_fd_clk,
  input  logic                      i_riscv_fd_rst,
  input  logic                      i_riscv_fd_stall,
  input  logic                      i_riscv_fd_flush,
  input  logic [`RISCV_FD_XLEN-1:0] i_riscv_fd_redirect_pc,
  input  logic [`RISCV_FD_XLEN-1:0] i_riscv_fd_pcnext,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_pc
);

  logic [`RISCV_FD_XLEN-1:0] pc_q;
  logic [`RISCV_FD_XLEN-1:0] pc_d;

  // ######################################################################
  // next pc select
  // ######################################################################
  always_comb
  begin
    if (i_riscv_fd_flush)
    begin
      pc_d = i_riscv_fd_redirect_pc;  // flush beats stall
    end
    else if (i_riscv_fd_stall)
    begin
      pc_d = pc_q;
    end
    else
    begin
      // +2 or +4, already worked out by the expander
      pc_d = i_riscv_fd_pcnext;
    end
  end

  // ######################################################################
  // pc register
  // ######################################################################
  always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
  begin
    if (i_riscv_fd_rst)
    begin
      pc_q <= `RISCV_FD_RESET_PC;
    end
    else
    begin
      pc_q <= pc_d;
    end
  end

  assign o_riscv_fd_pc = pc_q;  // straight to the imem address

endmodule

//--- logic/riscv_fd_cexpand.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_cexpand (
  input  logic [`RISCV_FD_XLEN-1:0] i_riscv_fd_pc,
  input  logic [`RISCV_FD_ILEN-1:0] i_riscv_fd_rdata,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_pcnext,
  riscv_fd_stage_if.fetch           o_riscv_fd_f
);

  import riscv_fd_pkg::*;

  logic        is_c;     // low two bits not 2'b11
  logic [15:0] c;        // compressed halfword
  logic [11:0] imm6_sx;  // c.addi / c.li immediate, sign-extended
  logic [11:0] joff;     // c.j offset, bit 0 always zero
  inst_u       exp_w;

  assign is_c = (i_riscv_fd_rdata[1:0] != 2'b11);
  assign c    = i_riscv_fd_rdata[15:0];

  assign imm6_sx = {{6{c[12]}}, c[12], c[6:2]};
  // imm[11|4|9:8|10|6|7|3:1|5] sits in bits 12..2
  assign joff    = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

  // ######################################################################
  // rvc subset expansion
  // ######################################################################
  always_comb
  begin
    exp_w.raw = '0;  // anything unsupported leaves a bubble
    case ({c[15:13], c[1:0]})
      5'b000_01:  // c.addi -> addi rd, rd, imm
      begin
        exp_w.i.imm_11_0 = imm6_sx;
        exp_w.i.rs1      = c[11:7];
        exp_w.i.rd       = c[11:7];
        exp_w.i.opcode   = `RISCV_FD_OP_OPIMM;
      end
      5'b010_01:  // c.li -> addi rd, x0, imm
      begin
        exp_w.i.imm_11_0 = imm6_sx;
        exp_w.i.rd       = c[11:7];
        exp_w.i.opcode   = `RISCV_FD_OP_OPIMM;
      end
      5'b101_01:  // c.j -> jal x0, offset
      begin
        exp_w.j.imm_20    = joff[11];
        exp_w.j.imm_19_12 = {8{joff[11]}};
        exp_w.j.imm_11    = joff[11];
        exp_w.j.imm_10_1  = joff[10:1];
        exp_w.j.opcode    = `RISCV_FD_OP_JAL;
      end
      5'b100_10:
      begin
        // rs2 of zero is jr/jalr/ebreak, not handled
        if (c[6:2] != 5'd0)
        begin
          exp_w.r.rs2    = c[6:2];
          exp_w.r.rs1    = c[12] ? c[11:7] : 5'd0;  // c.add vs c.mv
          exp_w.r.rd     = c[11:7];
          exp_w.r.opcode = `RISCV_FD_OP_OP;
        end
      end
      default:
      begin
        exp_w.raw = '0;
      end
    endcase
  end

  // ######################################################################
  // stage outputs
  // ######################################################################
  assign o_riscv_fd_pcnext = i_riscv_fd_pc + (is_c ? `RISCV_FD_XLEN'd2 : `RISCV_FD_XLEN'd4);

  assign o_riscv_fd_f.pc      = i_riscv_fd_pc;
  assign o_riscv_fd_f.inst    = is_c ? exp_w.raw : i_riscv_fd_rdata;
  assign o_riscv_fd_f.pcplus4 = o_riscv_fd_pcnext;
  assign o_riscv_fd_f.cinst   = is_c ? c : 16'd0;  // zero for 32-bit words

endmodule

//--- logic/riscv_fd_ppreg.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_ppreg (
  input  logic             i_riscv_fd_clk,
  input  logic             i_riscv_fd_rst,
  input  logic             i_riscv_fd_flush,
  input  logic             i_riscv_fd_stall,
  riscv_fd_stage_if.decode i_riscv_fd_f,    // from fetch
  riscv_fd_stage_if.fetch  o_riscv_fd_d     // towards decode
);

  // ######################################################################
  // fetch/decode register
  // ######################################################################
  always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
  begin
    if (i_riscv_fd_rst)
    begin
      o_riscv_fd_d.pc      <= `RISCV_FD_XLEN'd0;
      o_riscv_fd_d.inst    <= `RISCV_FD_ILEN'd0;
      o_riscv_fd_d.pcplus4 <= `RISCV_FD_XLEN'd0;
      o_riscv_fd_d.cinst   <= 16'd0;
    end
    else if (i_riscv_fd_flush)
    begin
      // zero word decodes as a bubble
      o_riscv_fd_d.pc      <= `RISCV_FD_XLEN'd0;
      o_riscv_fd_d.inst    <= `RISCV_FD_ILEN'd0;
      o_riscv_fd_d.pcplus4 <= `RISCV_FD_XLEN'd0;
      o_riscv_fd_d.cinst   <= 16'd0;
    end
    else if (i_riscv_fd_stall)
    begin
      // hold everything
      o_riscv_fd_d.pc      <= o_riscv_fd_d.pc;
      o_riscv_fd_d.inst    <= o_riscv_fd_d.inst;
      o_riscv_fd_d.pcplus4 <= o_riscv_fd_d.pcplus4;
      o_riscv_fd_d.cinst   <= o_riscv_fd_d.cinst;
    end
    else
    begin
      o_riscv_fd_d.pc      <= i_riscv_fd_f.pc;
      o_riscv_fd_d.inst    <= i_riscv_fd_f.inst;
      o_riscv_fd_d.pcplus4 <= i_riscv_fd_f.pcplus4;
      o_riscv_fd_d.cinst   <= i_riscv_fd_f.cinst;  // raw rvc for trace
    end
  end

endmodule

//--- logic/riscv_fd_decoder.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_decoder (
  riscv_fd_stage_if.decode          i_riscv_fd_d,
  output riscv_fd_pkg::inst_class_e o_riscv_fd_class,
  output logic [4:0]                o_riscv_fd_rd,
  output logic [4:0]                o_riscv_fd_rs1,
  output logic [4:0]                o_riscv_fd_rs2,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_imm,
  output logic                      o_riscv_fd_valid_d
);

  import riscv_fd_pkg::*;

  inst_u w;

  assign w = i_riscv_fd_d.inst;

  // ######################################################################
  // class, register fields and immediate per format
  // ######################################################################
  always_comb
  begin
    o_riscv_fd_class = ILLEGAL;
    o_riscv_fd_rd    = 5'd0;
    o_riscv_fd_rs1   = 5'd0;
    o_riscv_fd_rs2   = 5'd0;
    o_riscv_fd_imm   = '0;
    if (w.raw == '0)
    begin
      o_riscv_fd_class = BUBBLE;
    end
    else
    begin
      case (w.r.opcode)
        `RISCV_FD_OP_LUI, `RISCV_FD_OP_AUIPC:  // u-type
        begin
          o_riscv_fd_class = (w.r.opcode == `RISCV_FD_OP_LUI) ? LUI : AUIPC;
          o_riscv_fd_rd    = w.u.rd;
          o_riscv_fd_imm   = {{(`RISCV_FD_XLEN-32){w.u.imm_31_12[19]}}, w.u.imm_31_12, 12'd0};
        end
        `RISCV_FD_OP_JAL:  // j-type
        begin
          o_riscv_fd_class = JAL;
          o_riscv_fd_rd    = w.j.rd;
          o_riscv_fd_imm   = {{(`RISCV_FD_XLEN-21){w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
                              w.j.imm_11, w.j.imm_10_1, 1'b0};
        end
        `RISCV_FD_OP_JALR, `RISCV_FD_OP_LOAD, `RISCV_FD_OP_OPIMM:  // i-type
        begin
          o_riscv_fd_class = (w.i.opcode == `RISCV_FD_OP_JALR) ? JALR :
                             (w.i.opcode == `RISCV_FD_OP_LOAD) ? LOAD : OPIMM;
          o_riscv_fd_rd    = w.i.rd;
          o_riscv_fd_rs1   = w.i.rs1;
          o_riscv_fd_imm   = {{(`RISCV_FD_XLEN-12){w.i.imm_11_0[11]}}, w.i.imm_11_0};
        end
        `RISCV_FD_OP_BRANCH:  // b-type, no rd
        begin
          o_riscv_fd_class = BRANCH;
          o_riscv_fd_rs1   = w.b.rs1;
          o_riscv_fd_rs2   = w.b.rs2;
          o_riscv_fd_imm   = {{(`RISCV_FD_XLEN-13){w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                              w.b.imm_10_5, w.b.imm_4_1, 1'b0};
        end
        `RISCV_FD_OP_STORE:  // s-type
        begin
          o_riscv_fd_class = STORE;
          o_riscv_fd_rs1   = w.s.rs1;
          o_riscv_fd_rs2   = w.s.rs2;
          o_riscv_fd_imm   = {{(`RISCV_FD_XLEN-12){w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
        end
        `RISCV_FD_OP_OP:  // r-type, imm stays zero
        begin
          o_riscv_fd_class = OP;
          o_riscv_fd_rd    = w.r.rd;
          o_riscv_fd_rs1   = w.r.rs1;
          o_riscv_fd_rs2   = w.r.rs2;
        end
        default:
        begin
          o_riscv_fd_class = ILLEGAL;  // unknown opcode, fields left zero
        end
      endcase
    end
  end

  assign o_riscv_fd_valid_d = (o_riscv_fd_class != BUBBLE);

endmodule

//--- logic/riscv_fd_frontend.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_frontend (
  input  logic                      i_riscv_fd_clk,
  input  logic                      i_riscv_fd_rst,
  input  logic                      i_riscv_fd_stall,
  input  logic                      i_riscv_fd_flush,
  input  logic [`RISCV_FD_XLEN-1:0] i_riscv_fd_redirect_pc,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_imem_addr,
  input  logic [`RISCV_FD_ILEN-1:0] i_riscv_fd_imem_rdata,
  output riscv_fd_pkg::inst_class_e o_riscv_fd_class,
  output logic [4:0]                o_riscv_fd_rd,
  output logic [4:0]                o_riscv_fd_rs1,
  output logic [4:0]                o_riscv_fd_rs2,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_imm,
  output logic                      o_riscv_fd_valid_d,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_pc_d,
  output logic [`RISCV_FD_ILEN-1:0] o_riscv_fd_inst_d,
  output logic [`RISCV_FD_XLEN-1:0] o_riscv_fd_pcplus4_d,
  output logic [15:0]               o_riscv_fd_cinst_d
);

  logic [`RISCV_FD_XLEN-1:0] pc_f;      // current fetch address
  logic [`RISCV_FD_XLEN-1:0] pcnext_f;  // pc + 2 or pc + 4

  riscv_fd_stage_if f_if ();  // fetch side
  riscv_fd_stage_if d_if ();  // decode side

  // ######################################################################
  // fetch
  // ######################################################################
  riscv_fd_pcgen u_pcgen (
    .i_riscv_fd_clk         (i_riscv_fd_clk),
    .i_riscv_fd_rst         (i_riscv_fd_rst),
    .i_riscv_fd_stall       (i_riscv_fd_stall),
    .i_riscv_fd_flush       (i_riscv_fd_flush),
    .i_riscv_fd_redirect_pc (i_riscv_fd_redirect_pc),
    .i_riscv_fd_pcnext      (pcnext_f),
    .o_riscv_fd_pc          (pc_f)
  );

  assign o_riscv_fd_imem_addr = pc_f;

  riscv_fd_cexpand u_cexpand (
    .i_riscv_fd_pc     (pc_f),
    .i_riscv_fd_rdata  (i_riscv_fd_imem_rdata),
    .o_riscv_fd_pcnext (pcnext_f),
    .o_riscv_fd_f      (f_if.fetch)
  );

  // ######################################################################
  // pipeline register and decode
  // ######################################################################
  riscv_fd_ppreg u_ppreg (
    .i_riscv_fd_clk   (i_riscv_fd_clk),
    .i_riscv_fd_rst   (i_riscv_fd_rst),
    .i_riscv_fd_flush (i_riscv_fd_flush),
    .i_riscv_fd_stall (i_riscv_fd_stall),
    .i_riscv_fd_f     (f_if.decode),
    .o_riscv_fd_d     (d_if.fetch)
  );

  riscv_fd_decoder u_decoder (
    .i_riscv_fd_d       (d_if.decode),
    .o_riscv_fd_class   (o_riscv_fd_class),
    .o_riscv_fd_rd      (o_riscv_fd_rd),
    .o_riscv_fd_rs1     (o_riscv_fd_rs1),
    .o_riscv_fd_rs2     (o_riscv_fd_rs2),
    .o_riscv_fd_imm     (o_riscv_fd_imm),
    .o_riscv_fd_valid_d (o_riscv_fd_valid_d)
  );

  // registered fields out for trace
  assign o_riscv_fd_pc_d      = d_if.pc;
  assign o_riscv_fd_inst_d    = d_if.inst;
  assign o_riscv_fd_pcplus4_d = d_if.pcplus4;
  assign o_riscv_fd_cinst_d   = d_if.cinst;

endmodule

//--- dv/riscv_fd_clkgen.sv
`timescale 1ns/1ps

module riscv_fd_clkgen (
  output logic o_riscv_fd_clk,
  output logic o_riscv_fd_rst
);

  initial
  begin
    o_riscv_fd_clk = 1'b0;
    o_riscv_fd_rst = 1'b0;
    #1 o_riscv_fd_rst = 1'b1;       // rising edge for the async reset
    repeat (2) @(posedge o_riscv_fd_clk);
    o_riscv_fd_rst <= 1'b0;
  end

  always #20 o_riscv_fd_clk = ~o_riscv_fd_clk;  // 40 ns period

endmodule

//--- dv/riscv_fd_tb.sv
`timescale 1ns/1ps
`include "riscv_fd_macros.svh"

module riscv_fd_tb;

  import riscv_fd_pkg::*;

  localparam logic [63:0] REGION1 = `RISCV_FD_RESET_PC + 64'd1024;
  localparam logic [63:0] REGION2 = `RISCV_FD_RESET_PC + 64'd2048;
  localparam logic [63:0] REGION3 = `RISCV_FD_RESET_PC + 64'd3072;
  // per-test cycle budgets for reset, stream, mix, stall, flush, flush in stall and tail
  localparam int TIMEOUT_CYCLES = 10 + 30 + 30 + 28 + 12 + 12 + 4 + 50;

  logic clk, rst, stall, flush, valid_d;
  logic [63:0] redirect_pc, imem_addr, imm, pc_d, pcplus4_d;
  logic [31:0] imem_rdata, inst_d;
  logic [15:0] cinst_d;
  logic [4:0] rd, rs1, rs2;
  inst_class_e cls;
  logic [15:0] mem [0:2047];  // halfword memory holding 4 regions of 1 KiB
  logic [10:0] wr_idx, dut_idx, dut_idx_n;
  integer seed;
  int err_cnt = 0, err_start = 0, tests_passed = 0, tests_failed = 0, cycle_cnt = 0;

  // reference model state
  logic [63:0] exp_pc, exp_pc_d, exp_pp4_d, exp_imm, ref_next, redir_q, redir_qq;
  logic [31:0] exp_inst_d, ref_word;
  logic [15:0] exp_cinst_d;
  logic [10:0] ref_idx;
  logic [4:0] exp_rd, exp_rs1, exp_rs2;
  logic ref_is_c, exp_valid, rst_q, flush_q, flush_qq, hold_q;
  inst_class_e exp_class;
  logic [323:0] dut_outs, hold_snap;

  riscv_fd_clkgen u_clkgen (.o_riscv_fd_clk(clk), .o_riscv_fd_rst(rst));

  riscv_fd_frontend i_dut (
    .i_riscv_fd_clk(clk), .i_riscv_fd_rst(rst), .i_riscv_fd_stall(stall),
    .i_riscv_fd_flush(flush), .i_riscv_fd_redirect_pc(redirect_pc),
    .o_riscv_fd_imem_addr(imem_addr), .i_riscv_fd_imem_rdata(imem_rdata),
    .o_riscv_fd_class(cls), .o_riscv_fd_rd(rd), .o_riscv_fd_rs1(rs1),
    .o_riscv_fd_rs2(rs2), .o_riscv_fd_imm(imm), .o_riscv_fd_valid_d(valid_d),
    .o_riscv_fd_pc_d(pc_d), .o_riscv_fd_inst_d(inst_d),
    .o_riscv_fd_pcplus4_d(pcplus4_d), .o_riscv_fd_cinst_d(cinst_d)
  );

  function automatic logic [10:0] hw_index(input logic [63:0] addr);
    logic [63:0] off;
    off = addr - `RISCV_FD_RESET_PC;
    return off[11:1];
  endfunction

  // combinational imem read wrapping inside the array
  assign dut_idx    = hw_index(imem_addr);
  assign dut_idx_n  = dut_idx + 11'd1;
  assign imem_rdata = {mem[dut_idx_n], mem[dut_idx]};
  assign dut_outs   = {imem_addr, pc_d, pcplus4_d, imm, inst_d, cinst_d, cls, rd, rs1, rs2,
                       valid_d};

  // ######################################################################
  // reference model
  // ######################################################################
  function automatic logic [31:0] expand_rvc(input logic [15:0] c);
    logic [11:0] i6;
    logic [20:0] jo;
    i6 = {{7{c[12]}}, c[6:2]};
    jo = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    case ({c[15:13], c[1:0]})
      5'b000_01: return {i6, c[11:7], 3'b000, c[11:7], 7'b0010011};  // addi rd, rd
      5'b010_01: return {i6, 5'd0, 3'b000, c[11:7], 7'b0010011};     // addi rd, x0
      5'b101_01: return {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, 7'b1101111};
      5'b100_10: return (c[6:2] == 5'd0) ? 32'd0 :
                        {7'd0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], 7'b0110011};
      default:   return 32'd0;
    endcase
  endfunction

  assign ref_idx  = hw_index(exp_pc);
  assign ref_word = {mem[ref_idx + 11'd1], mem[ref_idx]};
  assign ref_is_c = (ref_word[1:0] != 2'b11);
  assign ref_next = exp_pc + (ref_is_c ? 64'd2 : 64'd4);

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      exp_pc <= `RISCV_FD_RESET_PC;
      {exp_pc_d, exp_inst_d, exp_pp4_d, exp_cinst_d} <= '0;
    end
    else if (flush)
    begin
      exp_pc <= redirect_pc;  // bubble into decode
      {exp_pc_d, exp_inst_d, exp_pp4_d, exp_cinst_d} <= '0;
    end
    else if (!stall)
    begin
      exp_pc      <= ref_next;
      exp_pc_d    <= exp_pc;
      exp_inst_d  <= ref_is_c ? expand_rvc(ref_word[15:0]) : ref_word;
      exp_pp4_d   <= ref_next;
      exp_cinst_d <= ref_is_c ? ref_word[15:0] : 16'd0;
    end
  end

  // expected decode of the registered word
  always_comb
  begin
    exp_class = ILLEGAL;
    {exp_rd, exp_rs1, exp_rs2} = '0;
    exp_imm = '0;
    case (exp_inst_d[6:0])
      `RISCV_FD_OP_LUI, `RISCV_FD_OP_AUIPC:
      begin
        exp_class = (exp_inst_d[6:0] == `RISCV_FD_OP_LUI) ? LUI : AUIPC;
        exp_rd    = exp_inst_d[11:7];
        exp_imm   = {{32{exp_inst_d[31]}}, exp_inst_d[31:12], 12'd0};
      end
      `RISCV_FD_OP_JAL:
      begin
        exp_class = JAL;
        exp_rd    = exp_inst_d[11:7];
        exp_imm   = {{44{exp_inst_d[31]}}, exp_inst_d[19:12], exp_inst_d[20],
                     exp_inst_d[30:21], 1'b0};
      end
      `RISCV_FD_OP_JALR, `RISCV_FD_OP_LOAD, `RISCV_FD_OP_OPIMM:
      begin
        exp_class = (exp_inst_d[6:0] == `RISCV_FD_OP_JALR) ? JALR :
                    (exp_inst_d[6:0] == `RISCV_FD_OP_LOAD) ? LOAD : OPIMM;
        {exp_rd, exp_rs1} = {exp_inst_d[11:7], exp_inst_d[19:15]};
        exp_imm   = {{52{exp_inst_d[31]}}, exp_inst_d[31:20]};
      end
      `RISCV_FD_OP_BRANCH, `RISCV_FD_OP_STORE:
      begin
        exp_class = (exp_inst_d[6:0] == `RISCV_FD_OP_BRANCH) ? BRANCH : STORE;
        {exp_rs1, exp_rs2} = {exp_inst_d[19:15], exp_inst_d[24:20]};
        exp_imm   = (exp_class == STORE) ?
                    {{52{exp_inst_d[31]}}, exp_inst_d[31:25], exp_inst_d[11:7]} :
                    {{52{exp_inst_d[31]}}, exp_inst_d[7], exp_inst_d[30:25],
                     exp_inst_d[11:8], 1'b0};
      end
      `RISCV_FD_OP_OP:
      begin
        exp_class = OP;
        {exp_rd, exp_rs1, exp_rs2} = {exp_inst_d[11:7], exp_inst_d[19:15], exp_inst_d[24:20]};
      end
      default: exp_class = ILLEGAL;
    endcase
    if (exp_inst_d == 32'd0)
      exp_class = BUBBLE;
  end

  assign exp_valid = (exp_inst_d != 32'd0);

  // history for the flush, stall and reset checks
  always @(posedge clk or posedge rst)
  begin
    if (rst)
      {rst_q, flush_q, flush_qq, hold_q} <= 4'b1000;
    else
    begin
      rst_q     <= 1'b0;
      flush_q   <= flush;
      redir_q   <= redirect_pc;
      flush_qq  <= flush_q && !flush && !stall;
      redir_qq  <= redir_q;
      hold_q    <= stall && !flush;
      hold_snap <= dut_outs;
    end
  end

  // ######################################################################
  // checks
  // ######################################################################
  task automatic flag_error(input string what, input logic [63:0] got, input logic [63:0] exp);
    $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    err_cnt++;
  endtask

  a_fetch_pc: assert property (@(posedge clk) imem_addr == exp_pc)
    else flag_error("fetch pc", $sampled(imem_addr), $sampled(exp_pc));
  a_pc_d: assert property (@(posedge clk) pc_d == exp_pc_d)
    else flag_error("pc_d", $sampled(pc_d), $sampled(exp_pc_d));
  a_inst_d: assert property (@(posedge clk) inst_d == exp_inst_d)
    else flag_error("inst_d", $sampled(inst_d), $sampled(exp_inst_d));
  a_pcplus4: assert property (@(posedge clk) pcplus4_d == exp_pp4_d)
    else flag_error("pcplus4_d", $sampled(pcplus4_d), $sampled(exp_pp4_d));
  a_cinst: assert property (@(posedge clk) cinst_d == exp_cinst_d)
    else flag_error("cinst_d", $sampled(cinst_d), $sampled(exp_cinst_d));
  a_class: assert property (@(posedge clk) cls == exp_class && valid_d == exp_valid)
    else flag_error("class", $sampled(cls), $sampled(exp_class));
  a_regs: assert property (@(posedge clk) {rd, rs1, rs2} == {exp_rd, exp_rs1, exp_rs2})
    else flag_error("rd/rs1/rs2", $sampled({rd, rs1, rs2}), $sampled({exp_rd, exp_rs1, exp_rs2}));
  a_imm: assert property (@(posedge clk) imm == exp_imm)
    else flag_error("imm", $sampled(imm), $sampled(exp_imm));
  a_reset: assert property (@(posedge clk) (rst || rst_q) |->
      imem_addr == `RISCV_FD_RESET_PC && cls == BUBBLE &&
      {pc_d, pcplus4_d, imm, inst_d, cinst_d, rd, rs1, rs2, valid_d} == '0)
    else flag_error("reset state", $sampled(imem_addr), `RISCV_FD_RESET_PC);
  a_hold: assert property (@(posedge clk) hold_q |-> dut_outs == hold_snap)
    else flag_error("stall hold", $sampled(dut_outs[63:0]), $sampled(hold_snap[63:0]));
  a_bubble: assert property (@(posedge clk) flush_q |-> !valid_d && cls == BUBBLE)
    else flag_error("flush bubble", $sampled(cls), BUBBLE);
  a_redirect: assert property (@(posedge clk) flush_qq |-> pc_d == redir_qq)
    else flag_error("redirect pc_d", $sampled(pc_d), $sampled(redir_qq));

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ######################################################################
  // stimulus
  // ######################################################################
  function automatic logic [31:0] make_word32(input logic [31:0] r, input int sel);
    logic [6:0] op [0:9] = '{`RISCV_FD_OP_LUI, `RISCV_FD_OP_AUIPC, `RISCV_FD_OP_JAL,
      `RISCV_FD_OP_JALR, `RISCV_FD_OP_BRANCH, `RISCV_FD_OP_LOAD, `RISCV_FD_OP_STORE,
      `RISCV_FD_OP_OPIMM, `RISCV_FD_OP_OP, 7'b0001111};  // last one decodes illegal
    return {r[31:7], op[sel]};
  endfunction

  function automatic logic [15:0] make_rvc(input logic [15:0] r, input int sel);
    logic [4:0] rs2;
    rs2 = (r[6:2] == 5'd0) ? 5'd1 : r[6:2];
    case (sel)
      0:       return {3'b000, r[12:2], 2'b01};         // c.addi
      1:       return {3'b010, r[12:2], 2'b01};         // c.li
      2:       return {4'b1000, r[11:7], rs2, 2'b10};   // c.mv
      3:       return {4'b1001, r[11:7], rs2, 2'b10};   // c.add
      default: return {3'b101, r[12:2], 2'b01};         // c.j
    endcase
  endfunction

  task automatic put_half(input logic [15:0] h);
    mem[wr_idx] <= h;
    wr_idx = wr_idx + 11'd1;
  endtask

  task automatic put_word(input logic [31:0] w);
    put_half(w[15:0]);
    put_half(w[31:16]);
  endtask

  task automatic fill_region(input logic [63:0] base, input int n, input bit mixed);
    logic [31:0] r;
    int k;
    @(posedge clk);
    wr_idx = hw_index(base);
    for (k = 0; k < n; k++)
    begin
      r = $random(seed);
      if (mixed && r[0])
        put_half(make_rvc(r[31:16], {$random(seed)} % 5));
      else
        put_word(make_word32(r, {$random(seed)} % 10));
    end
  endtask

  task automatic redirect_to(input logic [63:0] target);
    @(posedge clk);
    flush       <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);  // let this edge's checks report first
    if (err_cnt == err_start)
    begin
      tests_passed++;
      $display("test %s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, err_cnt - err_start);
    end
    err_start = err_cnt;
  endtask

  initial
  begin
    int i;
    int n;
    seed        = 32'hfa20;
    stall       = 1'b0;
    flush       = 1'b0;
    redirect_pc = `RISCV_FD_RESET_PC;
    for (i = 0; i < 2048; i++)
      mem[i] = {i[10:0], i[10:6]} ^ 16'hc3a5;
    @(posedge clk);
    while (rst)
      @(posedge clk);
    repeat (4) @(posedge clk);
    finish_test("reset");

    fill_region(REGION1, 24, 1'b0);
    redirect_to(REGION1);
    repeat (26) @(posedge clk);
    finish_test("stream32");

    fill_region(REGION2, 24, 1'b1);
    redirect_to(REGION2);
    repeat (26) @(posedge clk);
    finish_test("compressed mix");

    redirect_to(REGION2);
    repeat (4) @(posedge clk);
    n = 3 + {$random(seed)} % 8;
    stall <= 1'b1;
    repeat (n) @(posedge clk);
    stall <= 1'b0;
    repeat (10) @(posedge clk);
    finish_test("stall");

    fill_region(REGION3, 12, 1'b1);
    redirect_to(REGION3);
    repeat (6) @(posedge clk);
    finish_test("flush redirect");

    @(posedge clk);
    stall <= 1'b1;
    repeat (2) @(posedge clk);
    flush       <= 1'b1;  // flush wins over the stall still held
    redirect_pc <= REGION1 + 64'd8;
    @(posedge clk);
    flush <= 1'b0;
    stall <= 1'b0;
    repeat (6) @(posedge clk);
    finish_test("flush in stall");

    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("tests passed %0d, failed %0d, check errors %0d", tests_passed, tests_failed,
             err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- riscv_fd.f
+incdir+logic
logic/riscv_fd_pkg.sv
logic/riscv_fd_stage_if.sv
logic/riscv_fd_pcgen.sv
logic/riscv_fd_cexpand.sv
logic/riscv_fd_ppreg.sv
logic/riscv_fd_decoder.sv
logic/riscv_fd_frontend.sv
dv/riscv_fd_clkgen.sv
dv/riscv_fd_tb.sv

//--- Bender.yml
package:
  name: riscv_fd

sources:
  - include_dirs:
      - logic
    files:
      - logic/riscv_fd_pkg.sv
      - logic/riscv_fd_stage_if.sv
      - logic/riscv_fd_pcgen.sv
      - logic/riscv_fd_cexpand.sv
      - logic/riscv_fd_ppreg.sv
      - logic/riscv_fd_decoder.sv
      - logic/riscv_fd_frontend.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/riscv_fd_clkgen.sv
      - dv/riscv_fd_tb.sv
